// File: include/md_cfg.svh
`ifndef MD_CFG_SVH
`define MD_CFG_SVH

// Operand width of the unit.
`define MD_XLEN 32

// Iteration counter, wide enough to hold MD_XLEN.
`define MD_CNT_W 6

// Values of HI, LO and the backup pair after reset.
`define MD_HI_RST 32'h0000_0000
`define MD_LO_RST 32'h0000_0000

`endif

// File: src/md_pkg.sv
package md_pkg;

	// **********************************************************************
	// Operation codes seen on op_i.
	// **********************************************************************
	typedef enum logic [3:0] {
		NONE  = 4'd0,
		MULT  = 4'd1,
		MULTU = 4'd2,
		DIV   = 4'd3,
		DIVU  = 4'd4,
		MTHI  = 4'd5,
		MTLO  = 4'd6,
		MFHI  = 4'd7,
		MFLO  = 4'd8
	} md_op_e;

	// **********************************************************************
	// Controller states.
	// **********************************************************************
	typedef enum logic [1:0] {
		IDLE     = 2'd0,
		MUL_WAIT = 2'd1,
		DIV_WAIT = 2'd2
	} md_state_e;

endpackage

// File: src/md_if.sv
`timescale 1ns/1ps
`include "md_cfg.svh"

// Controller to one iterative datapath.
interface md_calc_if;
	logic                start;
	logic                is_signed;
	logic [`MD_XLEN-1:0] a;
	logic [`MD_XLEN-1:0] b;
	logic                done;
	logic [`MD_XLEN-1:0] res_hi;
	logic [`MD_XLEN-1:0] res_lo;
	logic                dbz;

	modport ctrl (output start, is_signed, a, b, input done, res_hi, res_lo, dbz);
	modport dp (input start, is_signed, a, b, output done, res_hi, res_lo, dbz);
endinterface

// Controller to the HI/LO register file.
interface md_hilo_if;
	logic                wr_hi;
	logic                wr_lo;
	logic                wr_both;
	logic [`MD_XLEN-1:0] d_hi;
	logic [`MD_XLEN-1:0] d_lo;
	logic                backup;
	logic                restore;
	logic [`MD_XLEN-1:0] hi;
	logic [`MD_XLEN-1:0] lo;

	modport ctrl (output wr_hi, wr_lo, wr_both, d_hi, d_lo, backup, restore, input hi, lo);
	modport regs (input wr_hi, wr_lo, wr_both, d_hi, d_lo, backup, restore, output hi, lo);
endinterface

// File: src/md_ctrl.sv
`timescale 1ns/1ps
`include "md_cfg.svh"

module md_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  logic                op_valid_i,
	input  md_pkg::md_op_e      op_i,
	input  logic [`MD_XLEN-1:0] a_i,
	input  logic [`MD_XLEN-1:0] b_i,
	input  logic                stop_i,
	input  logic                restore_i,
	output logic                op_ready_o,
	output logic                busy_o,
	output logic                invalid_o,
	output logic [`MD_XLEN-1:0] rd_data_o,
	md_calc_if.ctrl             mul,
	md_calc_if.ctrl             div,
	md_hilo_if.ctrl             hl
);

	md_pkg::md_state_e state;

	logic idle;
	logic accept;
	logic start_mul;
	logic start_div;
	logic mul_fin;
	logic div_fin;

	// **********************************************************************
	// Issue.
	// **********************************************************************
	assign idle       = (state == md_pkg::IDLE);
	assign op_ready_o = idle;
	assign busy_o     = ~idle;

	// Stop and restore take the whole cycle; no operation issues beside them.
	assign accept    = op_valid_i && idle && !stop_i && !restore_i;
	assign start_mul = accept && (op_i == md_pkg::MULT || op_i == md_pkg::MULTU);
	assign start_div = accept && (op_i == md_pkg::DIV || op_i == md_pkg::DIVU);

	// Operands go straight through; the datapaths latch them on start.
	assign mul.start     = start_mul;
	assign mul.is_signed = (op_i == md_pkg::MULT);
	assign mul.a         = a_i;
	assign mul.b         = b_i;

	assign div.start     = start_div;
	assign div.is_signed = (op_i == md_pkg::DIV);
	assign div.a         = a_i;
	assign div.b         = b_i;

	// **********************************************************************
	// Register writes.
	// **********************************************************************
	assign mul_fin = (state == md_pkg::MUL_WAIT) && mul.done && !stop_i;
	assign div_fin = (state == md_pkg::DIV_WAIT) && div.done && !stop_i;

	assign hl.wr_both = mul_fin || (div_fin && !div.dbz);
	assign hl.wr_hi   = accept && (op_i == md_pkg::MTHI);
	assign hl.wr_lo   = accept && (op_i == md_pkg::MTLO);
	assign hl.backup  = hl.wr_hi || hl.wr_lo;
	assign hl.restore = idle && restore_i && !stop_i;

	always_comb begin
		unique case (state)
			md_pkg::MUL_WAIT: begin
				hl.d_hi = mul.res_hi;
				hl.d_lo = mul.res_lo;
			end
			md_pkg::DIV_WAIT: begin
				hl.d_hi = div.res_hi;
				hl.d_lo = div.res_lo;
			end
			default: begin
				hl.d_hi = a_i;
				hl.d_lo = a_i;
			end
		endcase
	end

	// MFHI and MFLO read without taking a cycle.
	always_comb begin
		rd_data_o = '0;
		if (op_valid_i && idle) begin
			if (op_i == md_pkg::MFHI)
				rd_data_o = hl.hi;
			else if (op_i == md_pkg::MFLO)
				rd_data_o = hl.lo;
		end
	end

	// **********************************************************************
	// FSM.
	// **********************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= md_pkg::IDLE;
			invalid_o <= 1'b0;
		end else if (stop_i) begin
			state <= md_pkg::IDLE;
		end else begin
			unique case (state)
				md_pkg::IDLE: begin
					if (start_mul) begin
						state     <= md_pkg::MUL_WAIT;
						invalid_o <= 1'b0;
					end else if (start_div) begin
						state     <= md_pkg::DIV_WAIT;
						invalid_o <= 1'b0;
					end
				end
				md_pkg::MUL_WAIT: begin
					if (mul.done)
						state <= md_pkg::IDLE;
				end
				md_pkg::DIV_WAIT: begin
					if (div.done) begin
						state <= md_pkg::IDLE;
						if (div.dbz)
							invalid_o <= 1'b1;
					end
				end
				default: state <= md_pkg::IDLE;
			endcase
		end
	end

endmodule

// File: src/md_mul.sv
`timescale 1ns/1ps
`include "md_cfg.svh"

module md_mul (
	input  logic    clk,
	input  logic    rst,
	md_calc_if.dp   calc
);

	logic [`MD_XLEN-1:0]   a_mag;
	logic [`MD_XLEN-1:0]   b_mag;
	logic [`MD_XLEN-1:0]   mcand;
	logic [2*`MD_XLEN-1:0] prod;
	logic [2*`MD_XLEN-1:0] res;
	logic [`MD_XLEN:0]     sum;
	logic [`MD_CNT_W-1:0]  cnt;
	logic                  running;
	logic                  neg;
	logic                  last;

	// Signed operands become magnitudes; the sign is applied at the end.
	assign a_mag = (calc.is_signed && calc.a[`MD_XLEN-1]) ? -calc.a : calc.a;
	assign b_mag = (calc.is_signed && calc.b[`MD_XLEN-1]) ? -calc.b : calc.b;

	assign last = (cnt == `MD_CNT_W'(`MD_XLEN));

	// Upper half plus the multiplicand when the current multiplier bit is set.
	assign sum = {1'b0, prod[2*`MD_XLEN-1:`MD_XLEN]} +
		{1'b0, (prod[0] ? mcand : {`MD_XLEN{1'b0}})};

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			cnt     <= '0;
		end else if (calc.start) begin
			running <= 1'b1;
			cnt     <= '0;
		end else if (running) begin
			if (last)
				running <= 1'b0;
			else
				cnt <= cnt + 1'b1;
		end
	end

	// Product register shifts right; the low half starts as the multiplier.
	always_ff @(posedge clk) begin
		if (calc.start) begin
			mcand <= b_mag;
			prod  <= {{`MD_XLEN{1'b0}}, a_mag};
			neg   <= calc.is_signed && (calc.a[`MD_XLEN-1] ^ calc.b[`MD_XLEN-1]);
		end else if (running && !last) begin
			prod <= {sum, prod[`MD_XLEN-1:1]};
		end
	end

	assign res = neg ? -prod : prod;

	assign calc.done   = running && last;
	assign calc.res_hi = res[2*`MD_XLEN-1:`MD_XLEN];
	assign calc.res_lo = res[`MD_XLEN-1:0];
	assign calc.dbz    = 1'b0;

endmodule

// File: src/md_div.sv
`timescale 1ns/1ps
`include "md_cfg.svh"

module md_div (
	input  logic    clk,
	input  logic    rst,
	md_calc_if.dp   calc
);

	logic [`MD_XLEN-1:0]  a_mag;
	logic [`MD_XLEN-1:0]  b_mag;
	logic [`MD_XLEN-1:0]  dvsr;
	logic [`MD_XLEN-1:0]  rem;
	logic [`MD_XLEN-1:0]  quo;
	logic [`MD_XLEN:0]    shifted;
	logic [`MD_XLEN:0]    diff;
	logic [`MD_CNT_W-1:0] cnt;
	logic                 running;
	logic                 neg_q;
	logic                 neg_r;
	logic                 zero;
	logic                 last;

	assign a_mag = (calc.is_signed && calc.a[`MD_XLEN-1]) ? -calc.a : calc.a;
	assign b_mag = (calc.is_signed && calc.b[`MD_XLEN-1]) ? -calc.b : calc.b;

	assign last = (cnt == `MD_CNT_W'(`MD_XLEN));

	// Bring down the next dividend bit and try the subtraction.
	assign shifted = {rem, quo[`MD_XLEN-1]};
	assign diff    = shifted - {1'b0, dvsr};

	// **********************************************************************
	// Sequencing.
	// **********************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			cnt     <= '0;
		end else if (calc.start) begin
			running <= 1'b1;
			cnt     <= '0;
		end else if (running) begin
			if (last)
				running <= 1'b0;
			else if (zero)
				cnt <= `MD_CNT_W'(`MD_XLEN);  // skip straight to done
			else
				cnt <= cnt + 1'b1;
		end
	end

	// **********************************************************************
	// Restoring datapath.
	// **********************************************************************
	always_ff @(posedge clk) begin
		if (calc.start) begin
			dvsr  <= b_mag;
			rem   <= '0;
			quo   <= a_mag;
			zero  <= (calc.b == '0);
			neg_q <= calc.is_signed && (calc.a[`MD_XLEN-1] ^ calc.b[`MD_XLEN-1]);
			neg_r <= calc.is_signed && calc.a[`MD_XLEN-1];
		end else if (running && !last && !zero) begin
			if (!diff[`MD_XLEN]) begin
				rem <= diff[`MD_XLEN-1:0];
				quo <= {quo[`MD_XLEN-2:0], 1'b1};
			end else begin
				rem <= shifted[`MD_XLEN-1:0];
				quo <= {quo[`MD_XLEN-2:0], 1'b0};
			end
		end
	end

	// Quotient sign from both operands, remainder follows the dividend.
	assign calc.done   = running && last;
	assign calc.res_lo = neg_q ? -quo : quo;
	assign calc.res_hi = neg_r ? -rem : rem;
	assign calc.dbz    = calc.done && zero;

endmodule

// File: src/md_hilo.sv
`timescale 1ns/1ps
`include "md_cfg.svh"

module md_hilo (
	input  logic    clk,
	input  logic    rst,
	md_hilo_if.regs regs
);

	logic [`MD_XLEN-1:0] hi_q;
	logic [`MD_XLEN-1:0] lo_q;
	logic [`MD_XLEN-1:0] bk_hi;
	logic [`MD_XLEN-1:0] bk_lo;

	// **********************************************************************
	// Architectural HI/LO and the copy taken before each MTHI or MTLO.
	// **********************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			hi_q  <= `MD_HI_RST;
			lo_q  <= `MD_LO_RST;
			bk_hi <= `MD_HI_RST;
			bk_lo <= `MD_LO_RST;
		end else begin
			if (regs.restore) begin
				hi_q <= bk_hi;
				lo_q <= bk_lo;
			end else if (regs.wr_both) begin
				hi_q <= regs.d_hi;
				lo_q <= regs.d_lo;
			end else begin
				if (regs.wr_hi)
					hi_q <= regs.d_hi;
				if (regs.wr_lo)
					lo_q <= regs.d_lo;
			end

			// Old values, taken in the same cycle as the single write.
			if (regs.backup) begin
				bk_hi <= hi_q;
				bk_lo <= lo_q;
			end
		end
	end

	assign regs.hi = hi_q;
	assign regs.lo = lo_q;

endmodule

// File: src/md_unit.sv
`timescale 1ns/1ps
`include "md_cfg.svh"

module md_unit (
	input  logic                clk,
	input  logic                rst,
	input  logic                op_valid_i,
	input  md_pkg::md_op_e      op_i,
	input  logic [`MD_XLEN-1:0] a_i,
	input  logic [`MD_XLEN-1:0] b_i,
	input  logic                stop_i,
	input  logic                restore_i,
	output logic                op_ready_o,
	output logic                busy_o,
	output logic                invalid_o,
	output logic [`MD_XLEN-1:0] hi_o,
	output logic [`MD_XLEN-1:0] lo_o,
	output logic [`MD_XLEN-1:0] rd_data_o
);

	md_calc_if mul_if ();
	md_calc_if div_if ();
	md_hilo_if hl_if ();

	md_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.op_valid_i (op_valid_i),
		.op_i       (op_i),
		.a_i        (a_i),
		.b_i        (b_i),
		.stop_i     (stop_i),
		.restore_i  (restore_i),
		.op_ready_o (op_ready_o),
		.busy_o     (busy_o),
		.invalid_o  (invalid_o),
		.rd_data_o  (rd_data_o),
		.mul        (mul_if.ctrl),
		.div        (div_if.ctrl),
		.hl         (hl_if.ctrl)
	);

	md_mul u_mul (
		.clk  (clk),
		.rst  (rst),
		.calc (mul_if.dp)
	);

	md_div u_div (
		.clk  (clk),
		.rst  (rst),
		.calc (div_if.dp)
	);

	md_hilo u_hilo (
		.clk  (clk),
		.rst  (rst),
		.regs (hl_if.regs)
	);

	assign hi_o = hl_if.hi;
	assign lo_o = hl_if.lo;

endmodule

// File: sim/md_unit_assertions.sv
`timescale 1ns/1ps

module md_unit_assertions (
	input logic              clk,
	input logic              rst,
	input md_pkg::md_state_e state_i,
	input logic              op_ready_i,
	input logic              busy_i,
	input logic              stop_i,
	input logic              mul_start_i,
	input logic              div_start_i,
	input logic              mul_fin_i,
	input logic              div_fin_i
);

	int n_fail = 0;

	// An accepted multiply or divide holds off the next request.
	mul_start_waits: assert property (@(posedge clk) disable iff (rst)
		mul_start_i |=> (state_i == md_pkg::MUL_WAIT) && !op_ready_i)
		else begin
			$error("multiply accepted but the FSM did not wait with op_ready_o low");
			n_fail++;
		end

	div_start_waits: assert property (@(posedge clk) disable iff (rst)
		div_start_i |=> (state_i == md_pkg::DIV_WAIT) && !op_ready_i)
		else begin
			$error("divide accepted but the FSM did not wait with op_ready_o low");
			n_fail++;
		end

	// Busy ends only on a finished operation or a stop.
	busy_ends_on_finish: assert property (@(posedge clk) disable iff (rst)
		$fell(busy_i) |-> $past(mul_fin_i || div_fin_i || stop_i))
		else begin
			$error("busy_o fell without a finished operation or a stop");
			n_fail++;
		end

	// Start pulses last one cycle.
	mul_start_pulse: assert property (@(posedge clk) disable iff (rst)
		mul_start_i |=> !mul_start_i)
		else begin
			$error("multiplier start held for more than one cycle");
			n_fail++;
		end

	div_start_pulse: assert property (@(posedge clk) disable iff (rst)
		div_start_i |=> !div_start_i)
		else begin
			$error("divider start held for more than one cycle");
			n_fail++;
		end

endmodule

// File: sim/md_unit_check.sv
`timescale 1ns/1ps
`include "md_cfg.svh"

module md_unit_check (
	input  logic                clk,
	input  logic                rst,
	input  logic                chk_i,
	input  logic                rd_chk_i,
	input  md_pkg::md_op_e      op_i,
	input  logic [`MD_XLEN-1:0] exp_hi_i,
	input  logic [`MD_XLEN-1:0] exp_lo_i,
	input  logic [`MD_XLEN-1:0] exp_rd_i,
	input  logic                exp_inv_i,
	input  logic [`MD_XLEN-1:0] hi_i,
	input  logic [`MD_XLEN-1:0] lo_i,
	input  logic [`MD_XLEN-1:0] rd_data_i,
	input  logic                invalid_i,
	input  logic                op_ready_i,
	input  logic                busy_i,
	output int                  n_checks_o,
	output int                  n_errors_o
);

	int n_checks = 0;
	int n_errors = 0;

	assign n_checks_o = n_checks;
	assign n_errors_o = n_errors;

	// Outputs are settled by the falling edge.
	always @(negedge clk) begin
		int bad;
		bad = 0;
		if (!rst && (busy_i == op_ready_i)) begin
			$display("ERROR %0t busy_o expected %b got %b", $time, !op_ready_i, busy_i);
			n_errors++;
		end
		if (chk_i) begin
			if (hi_i !== exp_hi_i) begin
				$display("ERROR %0t hi_o expected %h got %h", $time, exp_hi_i, hi_i);
				bad++;
			end
			if (lo_i !== exp_lo_i) begin
				$display("ERROR %0t lo_o expected %h got %h", $time, exp_lo_i, lo_i);
				bad++;
			end
			if (invalid_i !== exp_inv_i) begin
				$display("ERROR %0t invalid_o expected %b got %b", $time, exp_inv_i, invalid_i);
				bad++;
			end
			if (rd_chk_i && (rd_data_i !== exp_rd_i)) begin
				$display("ERROR %0t rd_data_o expected %h got %h", $time, exp_rd_i, rd_data_i);
				bad++;
			end
			n_checks++;
			n_errors += bad;
			if (bad == 0)
				$display("check %0d %s passed", n_checks,
					(op_i == md_pkg::NONE) ? "RESTORE" : op_i.name());
			else
				$display("check %0d %s failed with %0d mismatches", n_checks,
					(op_i == md_pkg::NONE) ? "RESTORE" : op_i.name(), bad);
		end
	end

endmodule

// File: sim/md_unit_tb.sv
`timescale 1ns/1ps
`include "md_cfg.svh"

module md_unit_tb;

	localparam int N_RAND = 40;
	// Random multiplies and divides plus the directed operations.
	localparam int N_OPS = 2 * N_RAND + 20;
	localparam longint WATCHDOG_NS = 2 * N_OPS * (`MD_XLEN + 4) * 100;

	logic                clk;
	logic                rst;
	logic                op_valid;
	md_pkg::md_op_e      op;
	logic [`MD_XLEN-1:0] a;
	logic [`MD_XLEN-1:0] b;
	logic                stop;
	logic                restore;
	logic                op_ready;
	logic                busy;
	logic                invalid;
	logic [`MD_XLEN-1:0] hi;
	logic [`MD_XLEN-1:0] lo;
	logic [`MD_XLEN-1:0] rd_data;

	logic [`MD_XLEN-1:0] m_hi;
	logic [`MD_XLEN-1:0] m_lo;
	logic [`MD_XLEN-1:0] m_bk_hi;
	logic [`MD_XLEN-1:0] m_bk_lo;
	logic                m_inv;

	logic                chk;
	logic                rd_chk;
	md_pkg::md_op_e      chk_op;
	logic [`MD_XLEN-1:0] exp_hi;
	logic [`MD_XLEN-1:0] exp_lo;
	logic [`MD_XLEN-1:0] exp_rd;
	logic                exp_inv;
	int                  n_checks;
	int                  n_errors;

	md_unit DUT (
		.clk        (clk),
		.rst        (rst),
		.op_valid_i (op_valid),
		.op_i       (op),
		.a_i        (a),
		.b_i        (b),
		.stop_i     (stop),
		.restore_i  (restore),
		.op_ready_o (op_ready),
		.busy_o     (busy),
		.invalid_o  (invalid),
		.hi_o       (hi),
		.lo_o       (lo),
		.rd_data_o  (rd_data)
	);

	md_unit_check CHK (
		.clk        (clk),
		.rst        (rst),
		.chk_i      (chk),
		.rd_chk_i   (rd_chk),
		.op_i       (chk_op),
		.exp_hi_i   (exp_hi),
		.exp_lo_i   (exp_lo),
		.exp_rd_i   (exp_rd),
		.exp_inv_i  (exp_inv),
		.hi_i       (hi),
		.lo_i       (lo),
		.rd_data_i  (rd_data),
		.invalid_i  (invalid),
		.op_ready_i (op_ready),
		.busy_i     (busy),
		.n_checks_o (n_checks),
		.n_errors_o (n_errors)
	);

	bind md_ctrl md_unit_assertions u_assert (
		.clk         (clk),
		.rst         (rst),
		.state_i     (state),
		.op_ready_i  (op_ready_o),
		.busy_i      (busy_o),
		.stop_i      (stop_i),
		.mul_start_i (start_mul),
		.div_start_i (start_div),
		.mul_fin_i   (mul_fin),
		.div_fin_i   (div_fin)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the DUT did not finish the operations in time");
		$display("Test FAILED");
		$finish;
	end

	// **********************************************************************
	// Reference model over the packed state {hi, lo, backup hi, backup lo, invalid}.
	// **********************************************************************
	function automatic logic [4*`MD_XLEN:0] md_ref(input md_pkg::md_op_e o,
		input logic [`MD_XLEN-1:0] x, input logic [`MD_XLEN-1:0] y,
		input logic rs, input logic stopped, input logic [4*`MD_XLEN:0] st);
		logic [`MD_XLEN-1:0]          h;
		logic [`MD_XLEN-1:0]          l;
		logic [`MD_XLEN-1:0]          bh;
		logic [`MD_XLEN-1:0]          bl;
		logic                         inv;
		logic                         sgn;
		logic signed [2*`MD_XLEN-1:0] sx;
		logic signed [2*`MD_XLEN-1:0] sy;
		logic signed [2*`MD_XLEN-1:0] r;
		{h, l, bh, bl, inv} = st;
		sgn = (o == md_pkg::MULT) || (o == md_pkg::DIV);
		sx = {{`MD_XLEN{sgn & x[`MD_XLEN-1]}}, x};
		sy = {{`MD_XLEN{sgn & y[`MD_XLEN-1]}}, y};
		if (rs) begin
			h = bh;
			l = bl;
		end else if (stopped) begin
			inv = 1'b0;
		end else begin
			case (o)
				md_pkg::MULT, md_pkg::MULTU: begin
					r = sx * sy;
					{h, l} = r;
					inv = 1'b0;
				end
				md_pkg::DIV, md_pkg::DIVU: begin
					if (y == '0) begin
						inv = 1'b1;
					end else begin
						r = sx / sy;
						l = r[`MD_XLEN-1:0];
						r = sx % sy;
						h = r[`MD_XLEN-1:0];
						inv = 1'b0;
					end
				end
				md_pkg::MTHI: begin
					{bh, bl} = {h, l};
					h = x;
				end
				md_pkg::MTLO: begin
					{bh, bl} = {h, l};
					l = x;
				end
				default: ;
			endcase
		end
		return {h, l, bh, bl, inv};
	endfunction

	task automatic model_step(input md_pkg::md_op_e o, input logic [`MD_XLEN-1:0] x,
		input logic [`MD_XLEN-1:0] y, input logic rs, input logic stopped);
		{m_hi, m_lo, m_bk_hi, m_bk_lo, m_inv} = md_ref(o, x, y, rs, stopped,
			{m_hi, m_lo, m_bk_hi, m_bk_lo, m_inv});
	endtask

	function automatic logic [`MD_XLEN-1:0] pick_operand();
		logic [2:0] sel;
		sel = 3'($urandom);
		case (sel)
			3'd0: return '0;
			3'd1: return {1'b1, {(`MD_XLEN-1){1'b0}}};
			3'd2: return {1'b0, {(`MD_XLEN-1){1'b1}}};
			3'd3: return '1;
			3'd4: return `MD_XLEN'($urandom_range(15));
			default: return `MD_XLEN'($urandom);
		endcase
	endfunction

	// **********************************************************************
	// Stimulus.
	// **********************************************************************
	task automatic send(input md_pkg::md_op_e o, input logic [`MD_XLEN-1:0] x,
		input logic [`MD_XLEN-1:0] y);
		@(posedge clk);
		op_valid <= 1'b1;
		op       <= o;
		a        <= x;
		b        <= y;
		@(negedge clk);
		while (!op_ready)
			@(negedge clk);
		@(posedge clk);
		op_valid <= 1'b0;
		op       <= md_pkg::NONE;
	endtask

	task automatic run_check(input md_pkg::md_op_e o);
		@(negedge clk);
		while (busy)
			@(negedge clk);
		@(posedge clk);
		exp_hi  <= m_hi;
		exp_lo  <= m_lo;
		exp_inv <= m_inv;
		chk_op  <= o;
		chk     <= 1'b1;
		@(posedge clk);
		chk <= 1'b0;
	endtask

	task automatic do_op(input md_pkg::md_op_e o, input logic [`MD_XLEN-1:0] x,
		input logic [`MD_XLEN-1:0] y);
		send(o, x, y);
		model_step(o, x, y, 1'b0, 1'b0);
		run_check(o);
	endtask

	// MFHI and MFLO are compared while the request is still on the port.
	task automatic read_reg(input md_pkg::md_op_e o);
		@(posedge clk);
		op_valid <= 1'b1;
		op       <= o;
		exp_hi   <= m_hi;
		exp_lo   <= m_lo;
		exp_inv  <= m_inv;
		exp_rd   <= (o == md_pkg::MFHI) ? m_hi : m_lo;
		chk_op   <= o;
		chk      <= 1'b1;
		rd_chk   <= 1'b1;
		@(posedge clk);
		op_valid <= 1'b0;
		op       <= md_pkg::NONE;
		chk      <= 1'b0;
		rd_chk   <= 1'b0;
	endtask

	task automatic restore_regs();
		@(posedge clk);
		restore <= 1'b1;
		@(posedge clk);
		restore <= 1'b0;
		model_step(md_pkg::NONE, '0, '0, 1'b1, 1'b0);
		run_check(md_pkg::NONE);
	endtask

	task automatic stop_op(input md_pkg::md_op_e o, input logic [`MD_XLEN-1:0] x,
		input logic [`MD_XLEN-1:0] y);
		send(o, x, y);
		repeat (5) @(posedge clk);
		stop <= 1'b1;
		@(posedge clk);
		stop <= 1'b0;
		model_step(o, x, y, 1'b0, 1'b1);
		run_check(o);
	endtask

	initial begin
		logic [`MD_XLEN-1:0] x;
		logic [`MD_XLEN-1:0] y;
		void'($urandom(20271));
		rst = 1'b1;
		op_valid = 1'b0;
		op = md_pkg::NONE;
		a = '0;
		b = '0;
		stop = 1'b0;
		restore = 1'b0;
		chk = 1'b0;
		rd_chk = 1'b0;
		chk_op = md_pkg::NONE;
		exp_hi = '0;
		exp_lo = '0;
		exp_rd = '0;
		exp_inv = 1'b0;
		{m_hi, m_lo, m_bk_hi, m_bk_lo, m_inv} = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < N_RAND; i++) begin
			x = pick_operand();
			y = pick_operand();
			do_op(($urandom_range(1) == 1) ? md_pkg::MULT : md_pkg::MULTU, x, y);
		end
		for (int i = 0; i < N_RAND; i++) begin
			x = pick_operand();
			y = (i % 8 == 7) ? '0 : pick_operand();
			do_op(($urandom_range(1) == 1) ? md_pkg::DIV : md_pkg::DIVU, x, y);
		end

		do_op(md_pkg::MTHI, `MD_XLEN'($urandom), '0);
		read_reg(md_pkg::MFHI);
		do_op(md_pkg::MTLO, `MD_XLEN'($urandom), '0);
		read_reg(md_pkg::MFLO);
		restore_regs();
		do_op(md_pkg::MTHI, `MD_XLEN'($urandom), '0);
		restore_regs();
		read_reg(md_pkg::MFHI);

		stop_op(md_pkg::MULT, `MD_XLEN'($urandom), `MD_XLEN'($urandom));
		do_op(md_pkg::MULTU, `MD_XLEN'($urandom), `MD_XLEN'($urandom));
		stop_op(md_pkg::DIV, `MD_XLEN'($urandom), `MD_XLEN'($urandom_range(99, 1)));
		do_op(md_pkg::DIVU, `MD_XLEN'($urandom), `MD_XLEN'($urandom_range(99, 1)));

		// Second request is held on the port until the multiply finishes.
		x = `MD_XLEN'($urandom);
		y = `MD_XLEN'($urandom_range(999, 1));
		send(md_pkg::MULT, x, y);
		model_step(md_pkg::MULT, x, y, 1'b0, 1'b0);
		send(md_pkg::DIVU, y, x);
		model_step(md_pkg::DIVU, y, x, 1'b0, 1'b0);
		run_check(md_pkg::DIVU);
		read_reg(md_pkg::MFLO);

		repeat (2) @(posedge clk);
		$display("%0d checks run, %0d errors, %0d assertion failures", n_checks, n_errors,
			DUT.u_ctrl.u_assert.n_fail);
		if (n_errors == 0 && n_checks > 0 && DUT.u_ctrl.u_assert.n_fail == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: md_unit.f
+incdir+include
src/md_pkg.sv
src/md_if.sv
src/md_ctrl.sv
src/md_mul.sv
src/md_div.sv
src/md_hilo.sv
src/md_unit.sv
sim/md_unit_assertions.sv
sim/md_unit_check.sv
sim/md_unit_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0 --timescale 1ns/1ps
TOP       := md_unit_tb
FILELIST  := md_unit.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Test OK

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
